// File: Makefile
SOURCES := $(shell grep -v '^+' all.f)

.PHONY: run clean

run: obj_dir/Vtb_mem_system
	./obj_dir/Vtb_mem_system

# simulator binary per testbench top, rebuilt when a source or the list changes
obj_dir/V%: $(SOURCES) all.f
	verilator --binary --timing --assert --top-module $* -f all.f

clean:
	rm -rf obj_dir

// File: all.f
source/cache_pkg.sv
source/cache_fill_fsm.sv
source/cache_tag_array.sv
source/cache_data_array.sv
source/cache.sv
source/main_memory.sv
source/mem_system.sv
dv/mem_system_sva.sv
dv/tb_mem_system.sv

// File: dv/mem_system_input.txt
// columns: op addr wdata exp_rdata exp_hit, all hex
// op 0000 reads, op 0001 writes; exp_rdata is ignored on a write
// cold read, then another word of the same block
0000 0040 0000 a5e5 0000
0000 0046 0000 a5e3 0001
// write hit, read back, evict with tag 1, refill brings the written word
0001 0044 1234 0000 0001
0000 0044 0000 1234 0001
0000 0844 0000 ade1 0000
0000 0044 0000 1234 0000
0000 0040 0000 a5e5 0001
// write miss fills first and then lands as a hit
0001 0310 beef 0000 0000
0000 0310 0000 beef 0001
0000 0312 0000 a6b7 0001
0000 0b10 0000 aeb5 0000
0000 0310 0000 beef 0000
// set 12 shared by tags 0, 1 and 2
0000 0120 0000 a485 0000
0000 0920 0000 ac85 0000
0000 0120 0000 a485 0000
0000 0920 0000 ac85 0000
0000 1120 0000 b485 0000
0000 0920 0000 ac85 0000
// sets never touched since reset
0000 1ff0 0000 ba55 0000
0000 0000 0000 a5a5 0000

// File: dv/mem_system_sva.sv
`timescale 1ns/100ps

module mem_system_sva (
	input logic                   clk,
	input logic                   rst_n,
	input logic                   miss,
	input logic                   mem_valid,
	input logic                   mem_rd,
	input logic                   tag_we,
	input logic                   busy,
	input cache_pkg::fill_state_t state
);
	import cache_pkg::*;

	logic [3:0] rd_seen;                        // reads issued since the miss
	logic [3:0] valid_seen;                     // returned words since the miss

	// both counts restart when a miss opens a fill
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_seen    <= '0;
			valid_seen <= '0;
		end else if (state == IDLE && miss) begin
			rd_seen    <= '0;
			valid_seen <= '0;
		end else begin
			rd_seen    <= rd_seen + 4'(mem_rd);
			valid_seen <= valid_seen + 4'(mem_valid);
		end
	end

	// busy holds through the fill and drops right after the tag write
	a_busy_span: assert property (@(posedge clk) disable iff (!rst_n)
		busy |=> (busy != $past(tag_we)))
		else $error("busy ended before the tag write or ran past it");

	// the tag write rides on the eighth returned word and on no other
	a_finish_eighth_word: assert property (@(posedge clk) disable iff (!rst_n)
		tag_we == (mem_valid && valid_seen == 4'd7))
		else $error("tag write not on the eighth returned word");

	a_rd_in_fill: assert property (@(posedge clk) disable iff (!rst_n)
		mem_rd |-> (busy && rd_seen < 4'd8))
		else $error("memory read strobe outside the eight reads of a fill");

	a_valid_in_fill: assert property (@(posedge clk) disable iff (!rst_n)
		mem_valid |-> busy)
		else $error("memory returned a word with no fill running");

endmodule

bind cache_fill_fsm mem_system_sva u_fill_sva (
	.clk       (clk),
	.rst_n     (rst_n),
	.miss      (miss),
	.mem_valid (mem_valid),
	.mem_rd    (mem_rd),
	.tag_we    (tag_we),
	.busy      (busy),
	.state     (state)
);

// File: dv/tb_mem_system.sv
`timescale 1ns/100ps

module tb_mem_system;
	import cache_pkg::*;

	localparam int MEM_LATENCY  = 4;
	localparam int MEM_WORDS    = 4096;
	localparam int RESET_CYCLES = 2;
	localparam int FIELDS       = 5;            // op addr wdata exp_rdata exp_hit
	localparam int TABLE_DEPTH  = 512;          // 9-bit row index
	localparam int OP_CYCLES    = 12 + 8;       // worst fill plus slack, per access

	logic  clk;
	logic  rst_n;
	logic  mem_read;
	logic  mem_write;
	addr_t read_addr;
	addr_t write_addr;
	word_t write_data;
	word_t read_data;
	logic  busy;
	logic  finish;

	word_t op_table [TABLE_DEPTH];              // flat copy of the operation file
	int    n_ops;
	int    cycle_cnt;
	int    cycle_limit;

	mem_system #(
		.MEM_LATENCY (MEM_LATENCY),
		.MEM_WORDS   (MEM_WORDS)
	) mem_system_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.mem_read   (mem_read),
		.mem_write  (mem_write),
		.read_addr  (read_addr),
		.write_addr (write_addr),
		.write_data (write_data),
		.read_data  (read_data),
		.busy       (busy),
		.finish     (finish)
	);

	always #2 clk = ~clk;                       // 4 ns period

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("*** FAILED ***");
		$fatal(1);
	endtask

	task automatic check_value(input int op_num, input string name, input word_t got,
	                           input word_t exp);
		if (got !== exp)
			stop_with_failure($sformatf("error: op %0d %s = 0x%h, expected 0x%h",
			                            op_num, name, got, exp));
	endtask

	// hard stop if a fill never ends
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_limit > 0 && cycle_cnt >= cycle_limit)
			stop_with_failure($sformatf("run timed out after %0d cycles", cycle_cnt));
	end

	task automatic load_operations();
		int i;
		for (i = 0; i < TABLE_DEPTH; i++)
			op_table[9'(i)] = 16'hffff;         // unused rows mark the end of the list
		$readmemh("dv/mem_system_input.txt", op_table);
		n_ops = 0;
		while (n_ops < TABLE_DEPTH / FIELDS && op_table[9'(n_ops * FIELDS)] != 16'hffff)
			n_ops++;
		if (n_ops == 0)
			stop_with_failure("the operation file holds no accesses");
	endtask

	// one access, held until the cache takes it as a hit
	task automatic run_access(input int n);
		logic [8:0] row;
		word_t      op;
		word_t      addr;
		word_t      exp_data;
		word_t      exp_hit;
		word_t      got_data;
		word_t      finish_cnt;
		logic       saw_hit;
		row        = 9'(n * FIELDS);
		op         = op_table[row];
		addr       = op_table[row + 9'd1];
		exp_data   = op_table[row + 9'd3];
		exp_hit    = op_table[row + 9'd4];
		mem_read   = (op == 16'h0000);
		mem_write  = (op == 16'h0001);
		read_addr  = addr;
		write_addr = addr;
		write_data = op_table[row + 9'd2];
		@(negedge clk);
		got_data = read_data;                   // valid now if this is a hit
		check_value(n, "finish", {15'b0, finish}, 16'h0000);
		@(posedge clk);
		#1;
		saw_hit    = !busy;                     // busy only rises after a miss
		finish_cnt = '0;
		while (busy) begin
			@(negedge clk);
			if (finish)
				finish_cnt = finish_cnt + 16'd1;
			@(posedge clk);
			#1;
		end
		if (!saw_hit) begin
			check_value(n, "finish pulses", finish_cnt, 16'h0001);
			@(negedge clk);
			got_data = read_data;               // refilled block answers the held request
			@(posedge clk);
			#1;
			check_value(n, "busy after refill", {15'b0, busy}, 16'h0000);
		end
		check_value(n, "hit", {15'b0, saw_hit}, exp_hit);
		if (op == 16'h0000)
			check_value(n, "read_data", got_data, exp_data);
	endtask

	initial begin
		clk         = 1'b0;
		rst_n       = 1'b0;
		mem_read    = 1'b0;
		mem_write   = 1'b0;
		read_addr   = '0;
		write_addr  = '0;
		write_data  = '0;
		cycle_cnt   = 0;
		cycle_limit = 0;
		load_operations();
		cycle_limit = n_ops * OP_CYCLES + RESET_CYCLES + 4;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst_n = 1'b1;
		check_value(0, "busy after reset", {15'b0, busy}, 16'h0000);
		for (int i = 0; i < n_ops; i++)
			run_access(i);
		mem_read  = 1'b0;
		mem_write = 1'b0;
		repeat (2) @(posedge clk);
		$display("*** PASSED ***");
		$finish;
	end

endmodule

// File: source/cache.sv
`timescale 1ns/100ps

module cache (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             mem_read,    // pipeline read request, held
	input  logic             mem_write,   // pipeline write request, held
	input  cache_pkg::addr_t read_addr,
	input  cache_pkg::addr_t write_addr,
	input  cache_pkg::word_t write_data,
	input  logic             mem_valid,   // returned word from memory
	input  cache_pkg::word_t mem_rdata,
	output logic             mem_rd,      // fill read strobe
	output logic             mem_wr,      // write-through level
	output cache_pkg::addr_t mem_addr,
	output cache_pkg::word_t mem_wdata,
	output cache_pkg::word_t read_data,   // word from the data array
	output logic             busy,        // fill in progress
	output logic             finish       // fill done, pulses with the tag write
);
	import cache_pkg::*;

	addr_t     fill_addr;
	addr_t     arr_addr;                  // address seen by both arrays
	word_idx_t fill_word;
	word_idx_t arr_word;
	word_t     arr_wdata;
	tag_t      tag;
	set_t      set;
	logic      fill_we;                   // returned word goes into the array
	logic      tag_we;
	logic      hit;
	logic      miss;
	logic      write_hit;

	cache_fill_fsm u_fill_fsm (
		.clk       (clk),
		.rst_n     (rst_n),
		.miss      (miss),
		.miss_addr (arr_addr),
		.mem_valid (mem_valid),
		.mem_rd    (mem_rd),
		.fill_addr (fill_addr),
		.data_we   (fill_we),
		.fill_word (fill_word),
		.tag_we    (tag_we),
		.busy      (busy)
	);

	// fill owns the arrays while busy, else the pending access, write first
	assign arr_addr = busy      ? fill_addr  :
	                  mem_write ? write_addr : read_addr;

	assign tag      = arr_addr[15:TAG_LSB];
	assign set      = arr_addr[TAG_LSB-1:SET_LSB];
	assign arr_word = fill_we ? fill_word : arr_addr[SET_LSB-1:WORD_LSB];

	assign miss      = (mem_read || mem_write) && !hit; // fsm only acts on it in IDLE
	assign write_hit = mem_write && hit && !busy;
	assign arr_wdata = fill_we ? mem_rdata : write_data;

	cache_tag_array u_tag_array (
		.clk   (clk),
		.rst_n (rst_n),
		.set   (set),
		.tag   (tag),
		.we    (tag_we),
		.hit   (hit)
	);

	cache_data_array u_data_array (
		.clk   (clk),
		.set   (set),
		.word  (arr_word),
		.we    (fill_we || write_hit),
		.wdata (arr_wdata),
		.rdata (read_data)
	);

	// write-through waits for the fill, the refilled block then takes the write as a hit
	assign mem_wr    = mem_write && !busy;
	assign mem_addr  = mem_rd ? fill_addr  :
	                   mem_wr ? write_addr : read_addr;
	assign mem_wdata = write_data;
	assign finish    = tag_we;

endmodule

// File: source/cache_data_array.sv
`timescale 1ns/100ps

module cache_data_array (
	input  logic                 clk,
	input  cache_pkg::set_t      set,   // block select
	input  cache_pkg::word_idx_t word,  // word select inside the block
	input  logic                 we,    // write the selected word
	input  cache_pkg::word_t     wdata,
	output cache_pkg::word_t     rdata  // selected word, no clock
);
	import cache_pkg::*;

	// 128 blocks of 8 words, 2 KB of data
	word_t store [NUM_SETS][WORDS_PER_BLOCK];

	// only the addressed word changes, the rest of the block holds
	always_ff @(posedge clk) begin
		if (we)
			store[set][word] <= wdata;
	end

	assign rdata = store[set][word];    // read hit answers in the same cycle

endmodule

// File: source/cache_fill_fsm.sv
`timescale 1ns/100ps

module cache_fill_fsm (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 miss,       // requested access did not hit
	input  cache_pkg::addr_t     miss_addr,  // address of the missing access
	input  logic                 mem_valid,  // one returned word from memory
	output logic                 mem_rd,     // read strobe, one per word
	output cache_pkg::addr_t     fill_addr,  // address of the word being requested
	output logic                 data_we,    // store the returned word
	output cache_pkg::word_idx_t fill_word,  // slot of the returned word
	output logic                 tag_we,     // last word in, block becomes valid
	output logic                 busy
);
	import cache_pkg::*;

	fill_state_t         state;
	fill_state_t         state_nxt;
	logic [15:SET_LSB]   blk_base;           // tag and set of the block in flight
	word_idx_t           req_cnt;            // words requested so far
	word_idx_t           ret_cnt;            // words returned so far
	logic                last_req;
	logic                last_ret;

	assign last_req = (req_cnt == word_idx_t'(WORDS_PER_BLOCK - 1));
	assign last_ret = mem_valid && (ret_cnt == word_idx_t'(WORDS_PER_BLOCK - 1));

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (miss)
					state_nxt = REQUEST; // start the fill the cycle after the miss
			end
			REQUEST: begin
				if (last_req)
					state_nxt = WAIT;    // eighth read goes out this cycle
			end
			WAIT: begin
				if (last_ret)
					state_nxt = IDLE;    // tag written with the final word
			end
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= IDLE;
		else
			state <= state_nxt;
	end

	// request side counts through the block in order
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			req_cnt <= '0;
		else if (state == REQUEST)
			req_cnt <= req_cnt + 1'b1;   // wraps to 0 after the eighth read
		else
			req_cnt <= '0;
	end

	// returns come back in request order, so the count is the word slot
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			ret_cnt <= '0;
		else if (state == IDLE)
			ret_cnt <= '0;
		else if (mem_valid)
			ret_cnt <= ret_cnt + 1'b1;
	end

	// block base taken from the missing address as the fill starts
	always_ff @(posedge clk) begin
		if (state == IDLE && miss)
			blk_base <= miss_addr[15:SET_LSB];
	end

	assign busy      = (state != IDLE);
	assign mem_rd    = (state == REQUEST);
	assign fill_addr = {blk_base, req_cnt, {WORD_LSB{1'b0}}}; // base + 2*req_cnt
	assign data_we   = mem_valid && busy;
	assign fill_word = ret_cnt;
	assign tag_we    = last_ret && (state == WAIT);

endmodule

// File: source/cache_pkg.sv
package cache_pkg;

	// basic widths of the 16-bit pipeline
	typedef logic [15:0] addr_t;        // byte address
	typedef logic [15:0] word_t;        // one data word
	typedef logic [4:0]  tag_t;         // addr[15:11]
	typedef logic [6:0]  set_t;         // addr[10:4], one of 128 blocks
	typedef logic [2:0]  word_idx_t;    // addr[3:1], word inside a block

	// address layout  tttt tsss ssss www0
	localparam int TAG_LSB  = 11;       // lowest tag bit
	localparam int SET_LSB  = 4;        // lowest set index bit
	localparam int WORD_LSB = 1;        // lowest word select bit, bit 0 picks a byte

	localparam int WORDS_PER_BLOCK = 8; // 16 bytes per block
	localparam int NUM_SETS        = 128;

	// block fill controller states
	typedef enum logic [1:0] {
		IDLE    = 2'b00,                // no fill, cache answers from the arrays
		REQUEST = 2'b01,                // one memory read issued per cycle
		WAIT    = 2'b10                 // all reads issued, collecting returns
	} fill_state_t;

endpackage

// File: source/cache_tag_array.sv
`timescale 1ns/100ps

module cache_tag_array (
	input  logic            clk,
	input  logic            rst_n,
	input  cache_pkg::set_t set,    // selects one block
	input  cache_pkg::tag_t tag,    // tag to store or compare
	input  logic            we,     // store tag and mark block valid
	output logic            hit
);
	import cache_pkg::*;

	logic [NUM_SETS-1:0] valid;     // one valid bit per block
	tag_t                tags [NUM_SETS];

	// a block turns valid with its tag write
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			valid <= '0;
		else if (we)
			valid[set] <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (we)
			tags[set] <= tag;
	end

	// set decode and compare in one step
	assign hit = valid[set] && (tags[set] == tag);

endmodule

// File: source/main_memory.sv
`timescale 1ns/100ps

module main_memory #(
	parameter int MEM_LATENCY = 4,    // cycles from rd to valid, 1 or more
	parameter int MEM_WORDS   = 4096  // depth in words, power of two
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             rd,      // one word read per strobe
	input  logic             wr,      // word write at the clock edge
	input  cache_pkg::addr_t addr,    // byte address, wraps at the depth
	input  cache_pkg::word_t wdata,
	output logic             valid,   // pulse with each returned word
	output cache_pkg::word_t rdata
);
	import cache_pkg::*;

	localparam int IDX_BITS = $clog2(MEM_WORDS);

	word_t                 mem [MEM_WORDS];
	logic [IDX_BITS-1:0]   idx;                     // word index, byte bit dropped
	logic [MEM_LATENCY-1:0] vld_pipe;               // one bit per read in flight
	word_t                 dat_pipe [MEM_LATENCY];

	assign idx = addr[IDX_BITS+WORD_LSB-1:WORD_LSB];

	// every word starts as its own byte address xor a5a5
	initial begin
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] = word_t'(i << WORD_LSB) ^ 16'ha5a5;
	end

	always @(posedge clk) begin
		if (wr)
			mem[idx] <= wdata;
	end

	// valid shift chain, clears so no stale returns after reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			vld_pipe <= '0;
		end else begin
			vld_pipe[0] <= rd;
			for (int i = 1; i < MEM_LATENCY; i++)
				vld_pipe[i] <= vld_pipe[i-1];
		end
	end

	// data sampled at request time and carried alongside its valid bit
	always_ff @(posedge clk) begin
		dat_pipe[0] <= mem[idx];
		for (int i = 1; i < MEM_LATENCY; i++)
			dat_pipe[i] <= dat_pipe[i-1];
	end

	assign valid = vld_pipe[MEM_LATENCY-1];
	assign rdata = dat_pipe[MEM_LATENCY-1];  // only meaningful with valid

endmodule

// File: source/mem_system.sv
`timescale 1ns/100ps

module mem_system #(
	parameter int MEM_LATENCY = 4,
	parameter int MEM_WORDS   = 4096
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             mem_read,
	input  logic             mem_write,
	input  cache_pkg::addr_t read_addr,
	input  cache_pkg::addr_t write_addr,
	input  cache_pkg::word_t write_data,
	output cache_pkg::word_t read_data,
	output logic             busy,
	output logic             finish
);
	import cache_pkg::*;

	// cache to memory
	logic  mem_rd;
	logic  mem_wr;
	addr_t mem_addr;
	word_t mem_wdata;
	// memory to cache
	logic  mem_valid;
	word_t mem_rdata;

	cache u_cache (
		.clk        (clk),
		.rst_n      (rst_n),
		.mem_read   (mem_read),
		.mem_write  (mem_write),
		.read_addr  (read_addr),
		.write_addr (write_addr),
		.write_data (write_data),
		.mem_valid  (mem_valid),
		.mem_rdata  (mem_rdata),
		.mem_rd     (mem_rd),
		.mem_wr     (mem_wr),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata),
		.read_data  (read_data),
		.busy       (busy),
		.finish     (finish)
	);

	main_memory #(
		.MEM_LATENCY (MEM_LATENCY),
		.MEM_WORDS   (MEM_WORDS)
	) u_main_memory (
		.clk   (clk),
		.rst_n (rst_n),
		.rd    (mem_rd),
		.wr    (mem_wr),
		.addr  (mem_addr),
		.wdata (mem_wdata),
		.valid (mem_valid),
		.rdata (mem_rdata)
	);

endmodule
